// ==== design/mem_access_pkg.sv ====
package mem_access_pkg;

	// widths with a meaning of their own
	typedef logic [31:0] word_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [7:0]  bus_strb_t;
	typedef logic [3:0]  lane_mask_t;
	typedef logic [3:0]  txn_id_t;
	typedef logic [2:0]  access_size_t;

	typedef enum logic [3:0] {
		OP_NONE,
		OP_LW,
		OP_LH,
		OP_LHU,
		OP_LB,
		OP_LBU,
		OP_SW,
		OP_SH,
		OP_SB
	} mem_op_t;

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_WAIT_ARREADY,
		RD_ADDR_ACCEPTED,
		RD_WAIT_RESP,
		RD_RESP_TAKEN,
		RD_SECOND_START
	} read_state_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_WAIT_AWREADY,
		WR_ADDR_ACCEPTED,
		WR_WAIT_WREADY,
		WR_DATA_ACCEPTED,
		WR_WAIT_RESP,
		WR_RESP_TAKEN,
		WR_SECOND_START
	} write_state_t;

	// bus size codes
	localparam access_size_t SIZE_BYTE = 3'd0;
	localparam access_size_t SIZE_WORD = 3'd2;

	function automatic logic op_is_load(mem_op_t op);
		return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
	endfunction

	function automatic logic op_is_store(mem_op_t op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

endpackage

// ==== design/request_stage.sv ====
`timescale 1ns/1ps

module request_stage
	import mem_access_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    req_valid,
	input  mem_op_t req_op,
	input  word_t   req_addr,
	input  word_t   req_wdata,
	input  logic    read_done,
	input  logic    write_done,
	output logic    req_ready,
	output logic    held_valid,
	output mem_op_t held_op,
	output word_t   held_addr,
	output word_t   held_wdata,
	output txn_id_t held_tag,
	output logic    resp_valid
);

	txn_id_t tag_count;
	logic    done;
	logic    accept;

	// a request with no memory op finishes right away
	assign done = read_done || write_done || (held_op == OP_NONE);
	assign req_ready = !held_valid || done;
	assign resp_valid = held_valid && done;
	assign accept = req_valid && req_ready;

	// free-running transaction tag
	always_ff @(posedge clock) begin
		if (reset)
			tag_count <= '0;
		else
			tag_count <= tag_count + 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset)
			held_valid <= 1'b0;
		else if (req_ready)
			held_valid <= req_valid;
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			held_op    <= req_op;
			held_addr  <= req_addr;
			held_wdata <= req_wdata;
			held_tag   <= tag_count;
		end
	end

endmodule

// ==== design/access_planner.sv ====
`timescale 1ns/1ps

module access_planner
	import mem_access_pkg::*;
#(
	parameter word_t DEVICE_BASE  = 32'h1000_0000,
	parameter word_t DEVICE_LIMIT = 32'h1000_0fff
) (
	input  mem_op_t      held_op,
	input  word_t        held_addr,
	input  word_t        held_wdata,
	input  logic         read_second,
	input  logic         write_second,
	output logic         two_beats,
	output word_t        beat_addr,
	output lane_mask_t   beat_mask,
	output access_size_t access_size,
	output bus_data_t    wdata,
	output bus_strb_t    wstrb
);

	logic [1:0]  offset;
	logic [4:0]  shift;
	logic        second;
	lane_mask_t  base_mask;
	logic [7:0]  span;
	word_t       word_addr;
	logic [63:0] doubled;
	word_t       rotated;
	logic        in_device;

	assign offset = held_addr[1:0];
	assign shift = {offset, 3'b000};

	// only one FSM is active at a time
	assign second = read_second || write_second;

	// lanes of an aligned access
	always_comb begin
		case (held_op)
			OP_LW, OP_SW:
				base_mask = 4'b1111;
			OP_LH, OP_LHU, OP_SH:
				base_mask = 4'b0011;
			default:
				base_mask = 4'b0001;
		endcase
	end

	// low nibble is the first word, high nibble spills into the next
	assign span = {4'b0000, base_mask} << offset;
	assign two_beats = |span[7:4];

	assign word_addr = {held_addr[31:2], 2'b00};
	assign beat_addr = second ? word_addr + 32'd4 : word_addr;
	assign beat_mask = second ? span[7:4] : span[3:0];
	assign wstrb = {2{beat_mask}};

	// rotate store data left by the byte offset
	assign doubled = {held_wdata, held_wdata} << shift;
	assign rotated = doubled[63:32];
	assign wdata = {2{rotated}};

	// device window takes byte-sized transfers
	assign in_device = (held_addr >= DEVICE_BASE) && (held_addr <= DEVICE_LIMIT);
	assign access_size = in_device ? SIZE_BYTE : SIZE_WORD;

endmodule

// ==== design/read_fsm.sv ====
`timescale 1ns/1ps

module read_fsm
	import mem_access_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    held_valid,
	input  mem_op_t held_op,
	input  txn_id_t held_tag,
	input  logic    two_beats,
	input  logic    arready,
	input  logic    rvalid,
	input  txn_id_t rid,
	output logic    arvalid,
	output txn_id_t arid,
	output logic    rready,
	output logic    second_beat,
	output logic    beat_taken,
	output logic    read_done
);

	read_state_t state;
	logic        start;
	logic        last_beat;

	assign start = held_valid && op_is_load(held_op);
	assign last_beat = !two_beats || second_beat;

	// beats with a foreign ID are accepted but dropped
	assign beat_taken = rvalid && rready && (rid == arid);
	assign read_done = (state == RD_RESP_TAKEN) && last_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= RD_IDLE;
			arvalid     <= 1'b0;
			rready      <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (start) begin
						state   <= RD_WAIT_ARREADY;
						arvalid <= 1'b1;
					end
				end
				RD_WAIT_ARREADY: begin
					if (arready) begin
						state   <= RD_ADDR_ACCEPTED;
						arvalid <= 1'b0;
						rready  <= 1'b1;
					end
				end
				RD_ADDR_ACCEPTED, RD_WAIT_RESP: begin
					if (beat_taken) begin
						state  <= RD_RESP_TAKEN;
						rready <= 1'b0;
					end else begin
						state <= RD_WAIT_RESP;
					end
				end
				RD_RESP_TAKEN: begin
					if (last_beat) begin
						state       <= RD_IDLE;
						second_beat <= 1'b0;
					end else begin
						state       <= RD_SECOND_START;
						second_beat <= 1'b1;
					end
				end
				RD_SECOND_START: begin
					state   <= RD_WAIT_ARREADY;
					arvalid <= 1'b1;
				end
				default:
					state <= RD_IDLE;
			endcase
		end
	end

	// both beats reuse the tag of the request
	always_ff @(posedge clock) begin
		if (state == RD_IDLE && start)
			arid <= held_tag;
	end

endmodule

// ==== design/write_fsm.sv ====
`timescale 1ns/1ps

module write_fsm
	import mem_access_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    held_valid,
	input  mem_op_t held_op,
	input  txn_id_t held_tag,
	input  logic    two_beats,
	input  logic    awready,
	input  logic    wready,
	input  logic    bvalid,
	input  txn_id_t bid,
	output logic    awvalid,
	output txn_id_t awid,
	output logic    wvalid,
	output logic    bready,
	output logic    second_beat,
	output logic    write_done
);

	write_state_t state;
	logic         start;
	logic         last_beat;
	logic         resp_taken;

	assign start = held_valid && op_is_store(held_op);
	assign last_beat = !two_beats || second_beat;
	assign resp_taken = bvalid && bready && (bid == awid);
	assign write_done = (state == WR_RESP_TAKEN) && last_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= WR_IDLE;
			awvalid     <= 1'b0;
			wvalid      <= 1'b0;
			bready      <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (start) begin
						state   <= WR_WAIT_AWREADY;
						awvalid <= 1'b1;
					end
				end
				WR_WAIT_AWREADY: begin
					// data phase opens once the address is taken
					if (awready) begin
						state   <= WR_ADDR_ACCEPTED;
						awvalid <= 1'b0;
						wvalid  <= 1'b1;
					end
				end
				WR_ADDR_ACCEPTED, WR_WAIT_WREADY: begin
					if (wready) begin
						state  <= WR_DATA_ACCEPTED;
						wvalid <= 1'b0;
						bready <= 1'b1;
					end else begin
						state <= WR_WAIT_WREADY;
					end
				end
				WR_DATA_ACCEPTED, WR_WAIT_RESP: begin
					if (resp_taken) begin
						state  <= WR_RESP_TAKEN;
						bready <= 1'b0;
					end else begin
						state <= WR_WAIT_RESP;
					end
				end
				WR_RESP_TAKEN: begin
					if (last_beat) begin
						state       <= WR_IDLE;
						second_beat <= 1'b0;
					end else begin
						state       <= WR_SECOND_START;
						second_beat <= 1'b1;
					end
				end
				WR_SECOND_START: begin
					state   <= WR_WAIT_AWREADY;
					awvalid <= 1'b1;
				end
				default:
					state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == WR_IDLE && start)
			awid <= held_tag;
	end

endmodule

// ==== design/load_aligner.sv ====
`timescale 1ns/1ps

module load_aligner
	import mem_access_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  mem_op_t    held_op,
	input  word_t      held_addr,
	input  logic       two_beats,
	input  logic       second_beat,
	input  logic       beat_taken,
	input  lane_mask_t beat_mask,
	input  bus_data_t  rdata,
	output word_t      resp_rdata
);

	word_t       beat_word;
	word_t       first_q;
	word_t       merged;
	logic [63:0] doubled;
	word_t       aligned;
	word_t       extended;
	logic        last_beat;

	// bit 2 of the beat address flips on beat two
	assign beat_word = (held_addr[2] ^ second_beat) ? rdata[63:32] : rdata[31:0];
	assign last_beat = second_beat || !two_beats;

	// lanes of this beat come from the bus, the rest from beat one
	always_comb begin
		for (int i = 0; i < 4; i++)
			merged[8*i +: 8] = beat_mask[i] ? beat_word[8*i +: 8] : first_q[8*i +: 8];
	end

	// rotate right by the byte offset
	assign doubled = {merged, merged} >> {held_addr[1:0], 3'b000};
	assign aligned = doubled[31:0];

	always_comb begin
		case (held_op)
			OP_LH:
				extended = {{16{aligned[15]}}, aligned[15:0]};
			OP_LHU:
				extended = {16'h0000, aligned[15:0]};
			OP_LB:
				extended = {{24{aligned[7]}}, aligned[7:0]};
			OP_LBU:
				extended = {24'h00_0000, aligned[7:0]};
			default:
				extended = aligned;
		endcase
	end

	always_ff @(posedge clock) begin
		if (beat_taken && !second_beat)
			first_q <= beat_word;
	end

	// result held until the next load's last beat
	always_ff @(posedge clock) begin
		if (reset)
			resp_rdata <= '0;
		else if (beat_taken && last_beat)
			resp_rdata <= extended;
	end

endmodule

// ==== design/mem_access_top.sv ====
`timescale 1ns/1ps

module mem_access_top
	import mem_access_pkg::*;
#(
	parameter word_t DEVICE_BASE  = 32'h1000_0000,
	parameter word_t DEVICE_LIMIT = 32'h1000_0fff
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         req_valid,
	input  mem_op_t      req_op,
	input  word_t        req_addr,
	input  word_t        req_wdata,
	output logic         req_ready,
	output logic         resp_valid,
	output word_t        resp_rdata,
	output txn_id_t      arid,
	output word_t        araddr,
	output access_size_t arsize,
	output logic         arvalid,
	input  logic         arready,
	input  txn_id_t      rid,
	input  bus_data_t    rdata,
	input  logic         rvalid,
	output logic         rready,
	output txn_id_t      awid,
	output word_t        awaddr,
	output access_size_t awsize,
	output logic         awvalid,
	input  logic         awready,
	output bus_data_t    wdata,
	output bus_strb_t    wstrb,
	output logic         wvalid,
	input  logic         wready,
	input  txn_id_t      bid,
	input  logic         bvalid,
	output logic         bready
);

	logic         held_valid;
	mem_op_t      held_op;
	word_t        held_addr;
	word_t        held_wdata;
	txn_id_t      held_tag;
	logic         read_done;
	logic         write_done;
	logic         read_second;
	logic         write_second;
	logic         two_beats;
	logic         beat_taken;
	word_t        beat_addr;
	lane_mask_t   beat_mask;
	access_size_t access_size;

	// both address channels carry the same beat address and size
	assign araddr = beat_addr;
	assign awaddr = beat_addr;
	assign arsize = access_size;
	assign awsize = access_size;

	request_stage request_stage_inst (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.read_done  (read_done),
		.write_done (write_done),
		.req_ready  (req_ready),
		.held_valid (held_valid),
		.held_op    (held_op),
		.held_addr  (held_addr),
		.held_wdata (held_wdata),
		.held_tag   (held_tag),
		.resp_valid (resp_valid)
	);

	access_planner #(
		.DEVICE_BASE  (DEVICE_BASE),
		.DEVICE_LIMIT (DEVICE_LIMIT)
	) access_planner_inst (
		.held_op      (held_op),
		.held_addr    (held_addr),
		.held_wdata   (held_wdata),
		.read_second  (read_second),
		.write_second (write_second),
		.two_beats    (two_beats),
		.beat_addr    (beat_addr),
		.beat_mask    (beat_mask),
		.access_size  (access_size),
		.wdata        (wdata),
		.wstrb        (wstrb)
	);

	read_fsm read_fsm_inst (
		.clock       (clock),
		.reset       (reset),
		.held_valid  (held_valid),
		.held_op     (held_op),
		.held_tag    (held_tag),
		.two_beats   (two_beats),
		.arready     (arready),
		.rvalid      (rvalid),
		.rid         (rid),
		.arvalid     (arvalid),
		.arid        (arid),
		.rready      (rready),
		.second_beat (read_second),
		.beat_taken  (beat_taken),
		.read_done   (read_done)
	);

	write_fsm write_fsm_inst (
		.clock       (clock),
		.reset       (reset),
		.held_valid  (held_valid),
		.held_op     (held_op),
		.held_tag    (held_tag),
		.two_beats   (two_beats),
		.awready     (awready),
		.wready      (wready),
		.bvalid      (bvalid),
		.bid         (bid),
		.awvalid     (awvalid),
		.awid        (awid),
		.wvalid      (wvalid),
		.bready      (bready),
		.second_beat (write_second),
		.write_done  (write_done)
	);

	load_aligner load_aligner_inst (
		.clock       (clock),
		.reset       (reset),
		.held_op     (held_op),
		.held_addr   (held_addr),
		.two_beats   (two_beats),
		.second_beat (read_second),
		.beat_taken  (beat_taken),
		.beat_mask   (beat_mask),
		.rdata       (rdata),
		.resp_rdata  (resp_rdata)
	);

endmodule

// ==== testbench/tb_axi_memory.sv ====
`timescale 1ns/1ps

module tb_axi_memory
	import mem_access_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      decoy,
	input  txn_id_t   arid,
	input  word_t     araddr,
	input  logic      arvalid,
	output logic      arready,
	output txn_id_t   rid,
	output bus_data_t rdata,
	output logic      rvalid,
	input  logic      rready,
	input  txn_id_t   awid,
	input  word_t     awaddr,
	input  logic      awvalid,
	output logic      awready,
	input  bus_data_t wdata,
	input  bus_strb_t wstrb,
	input  logic      wvalid,
	output logic      wready,
	output txn_id_t   bid,
	output logic      bvalid,
	input  logic      bready
);

	logic [7:0]  mem [0:65535];
	integer      seed;
	logic [1:0]  ar_wait;
	logic [1:0]  aw_wait;
	logic [1:0]  w_wait;
	logic        r_pending;
	logic        r_decoy;
	txn_id_t     r_id;
	word_t       r_addr;
	logic        b_pending;
	txn_id_t     b_id;
	word_t       w_addr;
	logic [15:0] r_base;
	word_t       r_word;

	function automatic logic [1:0] stall_cycles();
		integer r;
		r = $random(seed);
		return r[1:0];
	endfunction

	initial begin
		seed = 20;
		arready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		rvalid = 1'b0;
		bvalid = 1'b0;
		rid = '0;
		bid = '0;
		rdata = '0;
		// fill depends on the full 16-bit address
		for (int a = 0; a < 65536; a++)
			mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;
	end

	// bookkeeping on the values seen just before each rising edge
	always @(posedge clock) begin
		if (reset) begin
			r_pending <= 1'b0;
			r_decoy   <= 1'b0;
			b_pending <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				r_pending <= 1'b1;
				r_decoy   <= decoy;
				r_id      <= arid;
				r_addr    <= araddr;
			end
			// a decoy beat is taken first, then the real one
			if (rvalid && rready) begin
				if (r_decoy)
					r_decoy <= 1'b0;
				else
					r_pending <= 1'b0;
			end
			if (awvalid && awready) begin
				w_addr <= awaddr;
				b_id   <= awid;
			end
			if (wvalid && wready) begin
				for (int i = 0; i < 4; i++) begin
					if (wstrb[4*w_addr[2] + i])
						mem[{w_addr[15:2], 2'b00} + i] <= wdata[32*w_addr[2] + 8*i +: 8];
				end
				b_pending <= 1'b1;
			end
			if (bvalid && bready)
				b_pending <= 1'b0;
		end
	end

	// outputs change on the falling edge
	always @(negedge clock) begin
		if (reset) begin
			arready = 1'b0;
			awready = 1'b0;
			wready = 1'b0;
			rvalid = 1'b0;
			bvalid = 1'b0;
			ar_wait = stall_cycles();
			aw_wait = stall_cycles();
			w_wait = stall_cycles();
		end else begin
			if (arready) begin
				arready = 1'b0;
				ar_wait = stall_cycles();
			end else if (arvalid) begin
				if (ar_wait == 2'd0)
					arready = 1'b1;
				else
					ar_wait = ar_wait - 2'd1;
			end
			if (awready) begin
				awready = 1'b0;
				aw_wait = stall_cycles();
			end else if (awvalid) begin
				if (aw_wait == 2'd0)
					awready = 1'b1;
				else
					aw_wait = aw_wait - 2'd1;
			end
			if (wready) begin
				wready = 1'b0;
				w_wait = stall_cycles();
			end else if (wvalid) begin
				if (w_wait == 2'd0)
					wready = 1'b1;
				else
					w_wait = w_wait - 2'd1;
			end
			rvalid = r_pending;
			if (r_pending) begin
				r_base = {r_addr[15:2], 2'b00};
				r_word = {mem[r_base + 16'd3], mem[r_base + 16'd2],
					mem[r_base + 16'd1], mem[r_base]};
				// wrong ID and junk data for the decoy
				rid = r_decoy ? ~r_id : r_id;
				if (r_decoy)
					rdata = 64'h0123_4567_89ab_cdef;
				else if (r_addr[2])
					rdata = {r_word, 32'hffff_ffff};
				else
					rdata = {32'hffff_ffff, r_word};
			end
			bvalid = b_pending;
			bid = b_id;
		end
	end

endmodule

// ==== testbench/tb_mem_access.sv ====
`timescale 1ns/1ps

module tb_mem_access
	import mem_access_pkg::*;
();

	localparam word_t DEVICE_BASE     = 32'h1000_0000;
	localparam word_t DEVICE_LIMIT    = 32'h1000_0fff;
	localparam int    FIELDS          = 5;
	localparam int    MAX_LINES       = 64;
	localparam int    CYCLES_PER_LINE = 40;
	// the misaligned lw after its store sees a wrong-ID beat first
	localparam int    DECOY_LINE      = 7;

	logic         clock = 1'b0;
	logic         reset;
	logic         req_valid;
	mem_op_t      req_op;
	word_t        req_addr;
	word_t        req_wdata;
	logic         req_ready;
	logic         resp_valid;
	word_t        resp_rdata;
	txn_id_t      arid;
	word_t        araddr;
	access_size_t arsize;
	logic         arvalid;
	logic         arready;
	txn_id_t      rid;
	bus_data_t    rdata;
	logic         rvalid;
	logic         rready;
	txn_id_t      awid;
	word_t        awaddr;
	access_size_t awsize;
	logic         awvalid;
	logic         awready;
	bus_data_t    wdata;
	bus_strb_t    wstrb;
	logic         wvalid;
	logic         wready;
	txn_id_t      bid;
	logic         bvalid;
	logic         bready;
	logic         decoy;

	word_t        stim [0:FIELDS*MAX_LINES-1];
	int           line_count = 0;
	int           limit_cycles = 0;
	int           ar_total = 0;
	int           aw_total = 0;
	int           ar_start = 0;
	int           aw_start = 0;
	int           monitor_errors = 0;
	int           check_errors = 0;
	int           passed = 0;
	int           failed = 0;
	int           cycle_count = 0;
	word_t        cur_addr = '0;
	mem_op_t      cur_op = OP_NONE;
	txn_id_t      expected_id = '0;

	always #2 clock = ~clock;

	mem_access_top #(
		.DEVICE_BASE  (DEVICE_BASE),
		.DEVICE_LIMIT (DEVICE_LIMIT)
	) mem_access_top_inst (.*);

	tb_axi_memory tb_axi_memory_inst (.*);

	// cycles since reset, which the tag counter follows modulo 16
	always @(posedge clock) begin
		if (reset)
			cycle_count <= 0;
		else
			cycle_count <= cycle_count + 1;
	end

	// address, ID and size of one handshake against the beat it should be
	task automatic check_address(input string channel, input word_t addr,
			input txn_id_t id, input access_size_t size, input int beat);
		word_t        expected_addr;
		access_size_t expected_size;
		expected_addr = {cur_addr[31:2], 2'b00} + 32'd4 * beat;
		if (cur_addr >= DEVICE_BASE && cur_addr <= DEVICE_LIMIT)
			expected_size = SIZE_BYTE;
		else
			expected_size = SIZE_WORD;
		if (addr !== expected_addr) begin
			$display("CHECK FAILED %saddr expected %h got %h", channel, expected_addr, addr);
			monitor_errors++;
		end
		if (id !== expected_id) begin
			$display("CHECK FAILED %sid expected %h got %h", channel, expected_id, id);
			monitor_errors++;
		end
		if (size !== expected_size) begin
			$display("CHECK FAILED %ssize expected %h got %h", channel, expected_size, size);
			monitor_errors++;
		end
	endtask

	// store bytes that fall in the word of this beat, in both halves
	task automatic check_strobe(input int beat);
		word_t     beat_word;
		word_t     byte_addr;
		int        bytes;
		bus_strb_t expected_strb;
		case (cur_op)
			OP_SW:
				bytes = 4;
			OP_SH:
				bytes = 2;
			default:
				bytes = 1;
		endcase
		expected_strb = '0;
		beat_word = {cur_addr[31:2], 2'b00} + 32'd4 * beat;
		for (int k = 0; k < bytes; k++) begin
			byte_addr = cur_addr + k;
			if ({byte_addr[31:2], 2'b00} == beat_word) begin
				expected_strb[byte_addr[1:0]] = 1'b1;
				expected_strb[4 + byte_addr[1:0]] = 1'b1;
			end
		end
		if (wstrb !== expected_strb) begin
			$display("CHECK FAILED wstrb expected %h got %h", expected_strb, wstrb);
			monitor_errors++;
		end
	endtask

	// sampled with the values from just before the edge
	always @(posedge clock) begin
		if (!reset && arvalid && arready) begin
			check_address("ar", araddr, arid, arsize, ar_total - ar_start);
			ar_total <= ar_total + 1;
		end
		if (!reset && awvalid && awready) begin
			check_address("aw", awaddr, awid, awsize, aw_total - aw_start);
			aw_total <= aw_total + 1;
		end
		// the address of this beat was counted on an earlier edge
		if (!reset && wvalid && wready)
			check_strobe(aw_total - aw_start - 1);
	end

	task automatic run_request(input int idx);
		mem_op_t op;
		word_t   addr;
		word_t   expected;
		int      beats;
		int      seen;
		int      other;
		int      errors_before;
		logic    is_load;
		op = mem_op_t'(stim[FIELDS*idx][3:0]);
		addr = stim[FIELDS*idx + 1];
		expected = stim[FIELDS*idx + 3];
		beats = int'(stim[FIELDS*idx + 4]);
		is_load = op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
		errors_before = check_errors + monitor_errors;
		if (!req_ready) begin
			$display("request %0d found req_ready low when it was due", idx);
			check_errors++;
			while (!req_ready)
				@(negedge clock);
		end
		cur_addr = addr;
		cur_op = op;
		// the tag is sampled on the edge that accepts this request
		expected_id = cycle_count[3:0];
		ar_start = ar_total;
		aw_start = aw_total;
		decoy = (idx == DECOY_LINE);
		req_valid = 1'b1;
		req_op = op;
		req_addr = addr;
		req_wdata = stim[FIELDS*idx + 2];
		@(negedge clock);
		req_valid = 1'b0;
		while (!resp_valid) begin
			if (req_ready) begin
				$display("request %0d saw req_ready high before resp_valid", idx);
				check_errors++;
			end
			@(negedge clock);
		end
		decoy = 1'b0;
		seen = is_load ? ar_total - ar_start : aw_total - aw_start;
		other = is_load ? aw_total - aw_start : ar_total - ar_start;
		if (is_load && resp_rdata !== expected) begin
			$display("CHECK FAILED resp_rdata expected %h got %h", expected, resp_rdata);
			check_errors++;
		end
		if (seen != beats) begin
			$display("CHECK FAILED %s handshakes expected %h got %h",
				is_load ? "ar" : "aw", beats, seen);
			check_errors++;
		end
		if (other != 0) begin
			$display("request %0d used the wrong address channel %0d times", idx, other);
			check_errors++;
		end
		if (check_errors + monitor_errors == errors_before) begin
			passed++;
			$display("request %0d %s %h ok", idx, op.name(), addr);
		end else begin
			failed++;
			$display("request %0d %s %h failed", idx, op.name(), addr);
		end
	endtask

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_NONE;
		req_addr = '0;
		req_wdata = '0;
		decoy = 1'b0;
		$readmemh("testbench/mem_access_stimulus.txt", stim);
		while (line_count < MAX_LINES && !$isunknown(stim[FIELDS*line_count]))
			line_count++;
		limit_cycles = line_count * CYCLES_PER_LINE + 10;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		if (line_count == 0)
			$display("no stimulus lines were read");
		for (int i = 0; i < line_count; i++)
			run_request(i);
		$display("%0d requests, %0d passed, %0d failed, %0d check errors",
			line_count, passed, failed, check_errors + monitor_errors);
		if (failed == 0 && check_errors + monitor_errors == 0 && line_count > 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// watchdog sized from the number of requests
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout after %0d cycles with requests still outstanding", limit_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== testbench/mem_access_stimulus.txt ====
// op code, address, store data, expected load result, address beats
// op codes 1 lw 2 lh 3 lhu 4 lb 5 lbu 6 sw 7 sh 8 sb
6 00000100 12345678 00000000 1
1 00000100 00000000 12345678 1
6 00000105 a1b2c3d4 00000000 2
1 00000105 00000000 a1b2c3d4 2
6 0000010a 0badf00d 00000000 2
1 0000010a 00000000 0badf00d 2
6 00000113 87654321 00000000 2
1 00000113 00000000 87654321 2
7 0000011b 000090fe 00000000 2
2 0000011b 00000000 ffff90fe 2
3 0000011b 00000000 000090fe 2
2 00000105 00000000 ffffc3d4 1
3 00000106 00000000 0000b2c3 1
8 00000121 00000080 00000000 1
4 00000121 00000000 ffffff80 1
5 00000121 00000000 00000080 1
4 00000102 00000000 00000034 1
6 10000040 55667788 00000000 1
1 10000040 00000000 55667788 1
8 10000fff 000000c3 00000000 1
4 10000fff 00000000 ffffffc3 1
6 10001000 01020304 00000000 1
3 10001002 00000000 00000102 1

// ==== mem_access.f ====
design/mem_access_pkg.sv
design/request_stage.sv
design/access_planner.sv
design/read_fsm.sv
design/write_fsm.sv
design/load_aligner.sv
design/mem_access_top.sv
testbench/tb_axi_memory.sv
testbench/tb_mem_access.sv

// ==== Bender.yml ====
package:
  name: mem_access

sources:
  - files:
      - design/mem_access_pkg.sv
      - design/request_stage.sv
      - design/access_planner.sv
      - design/read_fsm.sv
      - design/write_fsm.sv
      - design/load_aligner.sv
      - design/mem_access_top.sv
  - target: test
    files:
      - testbench/tb_axi_memory.sv
      - testbench/tb_mem_access.sv
